// File: hdl/pkt_consts.svh
`ifndef PKT_CONSTS_SVH
`define PKT_CONSTS_SVH

//////////////////////////////
// Switch dimensions
//////////////////////////////

// Ingress buffers and egress ports come in equal numbers
`define PKT_NUM_PORTS 3

// One byte per beat on every stream
`define PKT_DATA_W 8

// Destination address carried on the metadata stream
`define PKT_IP_W 32

// Per-buffer drop counter
`define PKT_COUNT_W 32

`endif

// File: hdl/pkt_pkg.sv
`include "pkt_consts.svh"

package pkt_pkg;

	//////////////////////////////
	// Widths with a meaning
	//////////////////////////////

	typedef logic [`PKT_DATA_W-1:0] byte_t;

	// IPv4 destination of a packet, or the address of an egress port
	typedef logic [`PKT_IP_W-1:0] ip_addr_t;

	// Buffer or port number
	typedef logic [1:0] port_idx_t;

	// One bit per buffer or per port
	typedef logic [`PKT_NUM_PORTS-1:0] port_mask_t;

	typedef logic [`PKT_COUNT_W-1:0] drop_count_t;

	// One stream beat, last marks the final byte of a packet
	typedef struct packed {
		byte_t data;
		logic last;
	} beat_t;

	//////////////////////////////
	// State machines
	//////////////////////////////

	// Egress scheduler
	typedef enum logic [1:0] {
		EG_IDLE,
		EG_FORWARD,
		EG_POP
	} egress_state_t;

	// Drop drain
	typedef enum logic [1:0] {
		DR_IDLE,
		DR_DRAIN,
		DR_POP
	} drop_state_t;

endpackage

// File: hdl/ip_port_mapper.sv
`include "pkt_consts.svh"

module ip_port_mapper #(
	// Index of the ingress buffer this mapper serves
	parameter pkt_pkg::port_idx_t SELF = 2'd0
) (
	input logic meta_valid,
	input pkt_pkg::ip_addr_t ip,
	input pkt_pkg::ip_addr_t port_ip [`PKT_NUM_PORTS],
	output pkt_pkg::port_mask_t dest_mask,
	output logic drop
);

	pkt_pkg::port_mask_t match;
	pkt_pkg::port_mask_t first;

	// Address compare against every egress port
	always_comb begin
		for (int j = 0; j < `PKT_NUM_PORTS; j++) begin
			match[j] = (ip == port_ip[j]);
		end
		// Own port is never a destination, this blocks replay
		match[SELF] = 1'b0;
	end

	// Duplicate port addresses resolve to the lowest port
	assign first = match & (~match + 1'b1);

	//////////////////////////////
	// Classification
	//////////////////////////////

	assign dest_mask = meta_valid ? first : '0;

	// Valid metadata with no usable port
	assign drop = meta_valid && (first == '0);

endmodule

// File: hdl/rr_arbiter.sv
`include "pkt_consts.svh"

module rr_arbiter (
	input logic clk,
	input logic resetn,
	input pkt_pkg::port_mask_t req,
	input logic take,
	output pkt_pkg::port_idx_t grant,
	output logic any
);

	localparam int NUM = `PKT_NUM_PORTS;

	// Index with top priority this round
	pkt_pkg::port_idx_t ptr;
	pkt_pkg::port_idx_t cand [NUM];

	// Candidates in priority order, starting at the pointer
	always_comb begin
		for (int k = 0; k < NUM; k++) begin
			cand[k] = pkt_pkg::port_idx_t'((int'(ptr) + k) % NUM);
		end
	end

	//////////////////////////////
	// Circular search
	//////////////////////////////

	// Walk from lowest priority up, so the last hit wins
	always_comb begin
		grant = '0;
		for (int k = NUM - 1; k >= 0; k--) begin
			if (req[cand[k]]) begin
				grant = cand[k];
			end
		end
	end

	assign any = |req;

	// Granted index drops to lowest priority
	always_ff @(posedge clk) begin
		if (!resetn) begin
			ptr <= '0;
		end else if (take && any) begin
			if (int'(grant) == NUM - 1) begin
				ptr <= '0;
			end else begin
				ptr <= grant + 1'b1;
			end
		end
	end

endmodule

// File: hdl/drop_handler.sv
module drop_handler (
	input logic clk,
	input logic resetn,
	input logic drop,
	input logic in_valid,
	input logic in_last,
	output logic data_ready,
	output logic meta_ready,
	output pkt_pkg::drop_count_t count
);

	pkt_pkg::drop_state_t state;

	//////////////////////////////
	// Drain state machine
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= pkt_pkg::DR_IDLE;
			count <= '0;
		end else begin
			case (state)
				pkt_pkg::DR_IDLE: begin
					// Count the drop as soon as it is seen
					if (drop) begin
						count <= count + 1'b1;
						state <= pkt_pkg::DR_DRAIN;
					end
				end
				pkt_pkg::DR_DRAIN: begin
					// Swallow bytes until the final one goes
					if (data_ready && in_valid && in_last) begin
						state <= pkt_pkg::DR_POP;
					end
				end
				pkt_pkg::DR_POP: begin
					state <= pkt_pkg::DR_IDLE;
				end
				default: begin
					state <= pkt_pkg::DR_IDLE;
				end
			endcase
		end
	end

	//////////////////////////////
	// Ready outputs
	//////////////////////////////

	// Accept every byte of the dropped packet
	assign data_ready = (state == pkt_pkg::DR_DRAIN);

	// One-cycle metadata pop after the last byte
	assign meta_ready = (state == pkt_pkg::DR_POP);

endmodule

// File: hdl/egress_port.sv
`include "pkt_consts.svh"

module egress_port (
	input logic clk,
	input logic resetn,

	// Buffers whose head packet targets this port
	input pkt_pkg::port_mask_t req,

	// Ingress byte streams of all buffers
	input pkt_pkg::port_mask_t in_valid,
	input pkt_pkg::beat_t in_beat [`PKT_NUM_PORTS],
	output pkt_pkg::port_mask_t data_ready,

	// Metadata pop, one bit per buffer
	output pkt_pkg::port_mask_t meta_ready,

	// Egress stream
	output logic out_valid,
	output pkt_pkg::beat_t out_beat,
	input logic out_ready
);

	pkt_pkg::egress_state_t state;

	// Buffer currently owned by this port
	pkt_pkg::port_idx_t sel;

	pkt_pkg::port_idx_t arb_grant;
	logic arb_any;
	logic take;
	logic beat_done;

	//////////////////////////////
	// Arbitration
	//////////////////////////////

	// A new choice is only taken while idle
	assign take = (state == pkt_pkg::EG_IDLE) && arb_any;

	rr_arbiter arb0 (
		.clk(clk),
		.resetn(resetn),
		.req(req),
		.take(take),
		.grant(arb_grant),
		.any(arb_any)
	);

	//////////////////////////////
	// Scheduler state machine
	//////////////////////////////

	// Final byte of the packet leaves the port
	assign beat_done = out_valid && out_ready && out_beat.last;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= pkt_pkg::EG_IDLE;
			sel <= '0;
		end else begin
			case (state)
				pkt_pkg::EG_IDLE: begin
					if (take) begin
						sel <= arb_grant;
						state <= pkt_pkg::EG_FORWARD;
					end
				end
				pkt_pkg::EG_FORWARD: begin
					// Whole packet goes before anything else is scheduled
					if (beat_done) begin
						state <= pkt_pkg::EG_POP;
					end
				end
				pkt_pkg::EG_POP: begin
					state <= pkt_pkg::EG_IDLE;
				end
				default: begin
					state <= pkt_pkg::EG_IDLE;
				end
			endcase
		end
	end

	//////////////////////////////
	// Stream steering
	//////////////////////////////

	// Data path is a plain mux, no added cycle per beat
	assign out_beat = in_beat[sel];

	always_comb begin
		out_valid = 1'b0;
		data_ready = '0;
		meta_ready = '0;
		case (state)
			pkt_pkg::EG_FORWARD: begin
				out_valid = in_valid[sel];
				// Egress back-pressure goes straight to the owned buffer
				data_ready[sel] = out_ready;
			end
			pkt_pkg::EG_POP: begin
				meta_ready[sel] = 1'b1;
			end
			default: begin
				out_valid = 1'b0;
			end
		endcase
	end

endmodule

// File: hdl/packet_arbiter.sv
`include "pkt_consts.svh"

module packet_arbiter (
	input logic clk,
	input logic resetn,

	// Ingress byte streams
	input pkt_pkg::port_mask_t in_valid,
	input pkt_pkg::beat_t in_beat [`PKT_NUM_PORTS],
	output pkt_pkg::port_mask_t in_ready,

	// Ingress metadata, destination IP of the head packet
	input pkt_pkg::port_mask_t meta_valid,
	input pkt_pkg::ip_addr_t meta_ip [`PKT_NUM_PORTS],
	output pkt_pkg::port_mask_t meta_ready,

	// Egress streams
	output pkt_pkg::port_mask_t out_valid,
	output pkt_pkg::beat_t out_beat [`PKT_NUM_PORTS],
	input pkt_pkg::port_mask_t out_ready,

	// Configuration and status
	input pkt_pkg::ip_addr_t port_ip [`PKT_NUM_PORTS],
	output pkt_pkg::drop_count_t drop_count [`PKT_NUM_PORTS]
);

	localparam int NUM = `PKT_NUM_PORTS;

	// Indexed by ingress buffer
	pkt_pkg::port_mask_t dest_mask [NUM];
	pkt_pkg::port_mask_t drop;
	pkt_pkg::port_mask_t dr_data_ready;
	pkt_pkg::port_mask_t dr_meta_ready;

	// Indexed by egress port
	pkt_pkg::port_mask_t port_req [NUM];
	pkt_pkg::port_mask_t eg_data_ready [NUM];
	pkt_pkg::port_mask_t eg_meta_ready [NUM];

	//////////////////////////////
	// Per-buffer classification
	//////////////////////////////

	for (genvar i = 0; i < NUM; i++) begin : g_buf
		ip_port_mapper #(
			.SELF(pkt_pkg::port_idx_t'(i))
		) mapper (
			.meta_valid(meta_valid[i]),
			.ip(meta_ip[i]),
			.port_ip(port_ip),
			.dest_mask(dest_mask[i]),
			.drop(drop[i])
		);

		drop_handler dropper (
			.clk(clk),
			.resetn(resetn),
			.drop(drop[i]),
			.in_valid(in_valid[i]),
			.in_last(in_beat[i].last),
			.data_ready(dr_data_ready[i]),
			.meta_ready(dr_meta_ready[i]),
			.count(drop_count[i])
		);
	end

	// Port j requests come from bit j of every mapper
	always_comb begin
		for (int j = 0; j < NUM; j++) begin
			for (int i = 0; i < NUM; i++) begin
				port_req[j][i] = dest_mask[i][j];
			end
		end
	end

	//////////////////////////////
	// Egress ports
	//////////////////////////////

	for (genvar j = 0; j < NUM; j++) begin : g_port
		egress_port port (
			.clk(clk),
			.resetn(resetn),
			.req(port_req[j]),
			.in_valid(in_valid),
			.in_beat(in_beat),
			.data_ready(eg_data_ready[j]),
			.meta_ready(eg_meta_ready[j]),
			.out_valid(out_valid[j]),
			.out_beat(out_beat[j]),
			.out_ready(out_ready[j])
		);
	end

	// A buffer is owned by its drop handler or by its single destination,
	// so the contributions never overlap
	always_comb begin
		in_ready = dr_data_ready;
		meta_ready = dr_meta_ready;
		for (int j = 0; j < NUM; j++) begin
			in_ready = in_ready | eg_data_ready[j];
			meta_ready = meta_ready | eg_meta_ready[j];
		end
	end

endmodule

// File: verification/packet_arbiter_assertions.sv
`include "pkt_consts.svh"

module packet_arbiter_assertions (
	input logic clk,
	input logic resetn,
	input pkt_pkg::port_mask_t meta_ready,
	input logic in_pop,
	input logic fwd,
	input pkt_pkg::port_idx_t sel,
	input logic out_valid,
	input logic out_ready,
	input pkt_pkg::beat_t out_beat,
	input logic ready_overlap
);

	timeunit 1ns;
	timeprecision 100ps;

	//////////////////////////////
	// Metadata pop
	//////////////////////////////

	// Pop lasts one cycle only
	assert property (@(posedge clk) disable iff (!resetn)
		(|meta_ready) |=> !(|meta_ready))
		else $error("meta_ready held for more than one cycle");

	// Pop only from the POP state, and to one buffer
	assert property (@(posedge clk) disable iff (!resetn)
		(|meta_ready) |-> (in_pop && $onehot(meta_ready)))
		else $error("meta_ready raised outside the POP state");

	//////////////////////////////
	// Egress forwarding
	//////////////////////////////

	assert property (@(posedge clk) disable iff (!resetn)
		(fwd && $past(fwd)) |-> $stable(sel))
		else $error("egress grant changed during forwarding");

	// Stalled beat must not move
	assert property (@(posedge clk) disable iff (!resetn)
		(out_valid && !out_ready) |=> $stable(out_beat))
		else $error("out_beat changed while stalled");

	// Each buffer is served by at most one egress port
	assert property (@(posedge clk) disable iff (!resetn)
		!ready_overlap)
		else $error("data_ready given to one buffer by more than one egress port");

endmodule

bind egress_port packet_arbiter_assertions eg_chk (
	.clk(clk),
	.resetn(resetn),
	.meta_ready(meta_ready),
	.in_pop(state == pkt_pkg::EG_POP),
	.fwd(state == pkt_pkg::EG_FORWARD),
	.sel(sel),
	.out_valid(out_valid),
	.out_ready(out_ready),
	.out_beat(out_beat),
	.ready_overlap(1'b0)
);

bind drop_handler packet_arbiter_assertions dr_chk (
	.clk(clk),
	.resetn(resetn),
	.meta_ready({2'b00, meta_ready}),
	.in_pop(state == pkt_pkg::DR_POP),
	.fwd(1'b0),
	.sel(2'd0),
	.out_valid(1'b0),
	.out_ready(1'b1),
	.out_beat(9'd0),
	.ready_overlap(1'b0)
);

bind packet_arbiter packet_arbiter_assertions own_chk (
	.clk(clk),
	.resetn(resetn),
	.meta_ready('0),
	.in_pop(1'b0),
	.fwd(1'b0),
	.sel(2'd0),
	.out_valid(1'b0),
	.out_ready(1'b1),
	.out_beat(9'd0),
	.ready_overlap(|((eg_data_ready[0] & eg_data_ready[1]) |
		(eg_data_ready[0] & eg_data_ready[2]) |
		(eg_data_ready[1] & eg_data_ready[2])))
);

// File: verification/packet_arbiter_tb.sv
`include "pkt_consts.svh"

module packet_arbiter_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM = `PKT_NUM_PORTS;
	localparam int NPKT = 60;
	localparam int MAXLEN = 12;
	// Every packet at its longest, slow handshakes, plus margin
	localparam int WATCHDOG_NS = 180 * MAXLEN * 4 * 8 + 20000;

	logic clk;
	logic resetn;
	pkt_pkg::port_mask_t in_valid;
	pkt_pkg::beat_t in_beat [NUM];
	pkt_pkg::port_mask_t in_ready;
	pkt_pkg::port_mask_t meta_valid;
	pkt_pkg::ip_addr_t meta_ip [NUM];
	pkt_pkg::port_mask_t meta_ready;
	pkt_pkg::port_mask_t out_valid;
	pkt_pkg::beat_t out_beat [NUM];
	pkt_pkg::port_mask_t out_ready;
	pkt_pkg::ip_addr_t port_ip [NUM];
	pkt_pkg::drop_count_t drop_count [NUM];

	// Generated traffic
	int pkt_len [NUM][NPKT];
	pkt_pkg::ip_addr_t pkt_ip [NUM][NPKT];
	pkt_pkg::byte_t pkt_byte [NUM][NPKT][MAXLEN];

	// Model state, queues indexed by src * NUM + dst
	int fwd_q [NUM*NUM][$];
	pkt_pkg::drop_count_t exp_drops [NUM];

	int next_pkt [NUM];
	int next_byte [NUM];
	logic cur_busy [NUM];
	int cur_src [NUM];
	int cur_idx [NUM];
	int cur_pos [NUM];

	packet_arbiter dut0 (
		.clk(clk),
		.resetn(resetn),
		.in_valid(in_valid),
		.in_beat(in_beat),
		.in_ready(in_ready),
		.meta_valid(meta_valid),
		.meta_ip(meta_ip),
		.meta_ready(meta_ready),
		.out_valid(out_valid),
		.out_beat(out_beat),
		.out_ready(out_ready),
		.port_ip(port_ip),
		.drop_count(drop_count)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	//////////////////////////////
	// Checks
	//////////////////////////////

	task automatic stop_on_error(input string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic check_beat(input string name, input pkt_pkg::beat_t got,
			input pkt_pkg::beat_t exp);
		if (got !== exp) begin
			stop_on_error($sformatf("** Error %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_count(input string name, input pkt_pkg::drop_count_t got,
			input pkt_pkg::drop_count_t exp);
		if (got !== exp) begin
			stop_on_error($sformatf("** Error %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_mask(input string name, input pkt_pkg::port_mask_t got,
			input pkt_pkg::port_mask_t exp);
		if (got !== exp) begin
			stop_on_error($sformatf("** Error %s got %h expected %h", name, got, exp));
		end
	endtask

	function automatic pkt_pkg::ip_addr_t unmatched_ip();
		pkt_pkg::ip_addr_t a;
		a = $urandom;
		while (a == port_ip[0] || a == port_ip[1] || a == port_ip[2]) begin
			a = $urandom;
		end
		return a;
	endfunction

	// Traffic and expected results together
	task automatic build_traffic();
		int r;
		for (int i = 0; i < NUM; i++) begin
			exp_drops[i] = '0;
			for (int k = 0; k < NPKT; k++) begin
				pkt_len[i][k] = 1 + ($urandom % MAXLEN);
				r = $urandom % 4;
				pkt_ip[i][k] = (r < NUM) ? port_ip[r] : unmatched_ip();
				// First byte tags source and sequence
				pkt_byte[i][k][0] = {i[1:0], k[5:0]};
				for (int b = 1; b < MAXLEN; b++) begin
					pkt_byte[i][k][b] = $urandom;
				end
				if (r < NUM && r != i) begin
					fwd_q[i*NUM+r].push_back(k);
				end else begin
					exp_drops[i] = exp_drops[i] + 1'b1;
				end
			end
		end
	endtask

	function automatic bit all_done();
		for (int i = 0; i < NUM; i++) begin
			if (next_pkt[i] < NPKT || cur_busy[i]) return 1'b0;
		end
		for (int q = 0; q < NUM * NUM; q++) begin
			if (fwd_q[q].size() != 0) return 1'b0;
		end
		return 1'b1;
	endfunction

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	always @(posedge clk) begin : drive_ingress
		int k;
		bit hold;
		if (!resetn) begin
			in_valid <= '0;
			meta_valid <= '0;
			for (int i = 0; i < NUM; i++) begin
				next_pkt[i] = 0;
				next_byte[i] = 0;
			end
		end else begin
			for (int i = 0; i < NUM; i++) begin
				if (in_valid[i] && in_ready[i]) next_byte[i]++;
				if (meta_valid[i] && meta_ready[i]) begin
					next_pkt[i]++;
					next_byte[i] = 0;
				end
				k = next_pkt[i];
				hold = in_valid[i] && !in_ready[i];
				if (k >= NPKT) begin
					meta_valid[i] <= 1'b0;
					in_valid[i] <= 1'b0;
				end else begin
					meta_valid[i] <= 1'b1;
					meta_ip[i] <= pkt_ip[i][k];
					if (!hold) begin
						if (next_byte[i] < pkt_len[i][k] && ($urandom % 4) != 0) begin
							in_valid[i] <= 1'b1;
							in_beat[i].data <= pkt_byte[i][k][next_byte[i]];
							in_beat[i].last <= (next_byte[i] == pkt_len[i][k] - 1);
						end else begin
							in_valid[i] <= 1'b0;
						end
					end
				end
			end
		end
	end

	always @(posedge clk) begin
		if (!resetn) begin
			out_ready <= '0;
		end else begin
			for (int j = 0; j < NUM; j++) begin
				out_ready[j] <= ($urandom % 4) != 0;
			end
		end
	end

	//////////////////////////////
	// Egress monitor
	//////////////////////////////

	always @(posedge clk) begin : watch_egress
		pkt_pkg::beat_t exp;
		int src;
		if (resetn) begin
			for (int j = 0; j < NUM; j++) begin
				if (out_valid[j] && out_ready[j]) begin
					if (!cur_busy[j]) begin
						src = out_beat[j].data[7:6];
						if (src >= NUM || fwd_q[src*NUM+j].size() == 0) begin
							stop_on_error($sformatf(
								"egress %0d sent a packet that was not expected", j));
						end
						cur_src[j] = src;
						cur_idx[j] = fwd_q[src*NUM+j].pop_front();
						cur_pos[j] = 0;
						cur_busy[j] = 1'b1;
					end
					exp.data = pkt_byte[cur_src[j]][cur_idx[j]][cur_pos[j]];
					exp.last = (cur_pos[j] == pkt_len[cur_src[j]][cur_idx[j]] - 1);
					check_beat($sformatf("out_beat[%0d]", j), out_beat[j], exp);
					cur_pos[j]++;
					if (exp.last) cur_busy[j] = 1'b0;
				end
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		stop_on_error("run timed out before all packets were handled");
	end

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		void'($urandom(32'h808));
		resetn = 1'b0;
		in_valid = '0;
		meta_valid = '0;
		out_ready = '0;
		for (int i = 0; i < NUM; i++) begin
			in_beat[i] = '0;
			meta_ip[i] = '0;
			cur_busy[i] = 1'b0;
		end
		// Distinct port addresses
		port_ip[0] = $urandom;
		port_ip[1] = $urandom;
		while (port_ip[1] == port_ip[0]) port_ip[1] = $urandom;
		port_ip[2] = $urandom;
		while (port_ip[2] == port_ip[0] || port_ip[2] == port_ip[1]) port_ip[2] = $urandom;
		build_traffic();

		repeat (4) @(posedge clk);
		@(negedge clk);
		check_mask("out_valid", out_valid, '0);
		check_mask("in_ready", in_ready, '0);
		check_mask("meta_ready", meta_ready, '0);
		for (int i = 0; i < NUM; i++) begin
			check_count($sformatf("drop_count[%0d]", i), drop_count[i], '0);
		end
		@(posedge clk);
		resetn <= 1'b1;

		while (!all_done()) @(posedge clk);
		repeat (10) @(posedge clk);
		@(negedge clk);
		for (int i = 0; i < NUM; i++) begin
			check_count($sformatf("drop_count[%0d]", i), drop_count[i], exp_drops[i]);
		end
		$display("all tests passed");
		$finish;
	end

endmodule

// File: all.f
+incdir+hdl
hdl/pkt_pkg.sv
hdl/ip_port_mapper.sv
hdl/rr_arbiter.sv
hdl/drop_handler.sv
hdl/egress_port.sv
hdl/packet_arbiter.sv
verification/packet_arbiter_assertions.sv
verification/packet_arbiter_tb.sv
